/* compile.f */
+incdir+rtl
rtl/raycast_pkg.sv
rtl/debouncer.sv
rtl/fxp_rotate.sv
rtl/movement_control.sv
rtl/btn_control.sv
tests/tb_btn_control.sv

/* rtl/btn_control.sv */
`timescale 1ns/1ps

module btn_control (
    input  logic                       clk_in,
    input  logic                       rst_in,
    input  logic                       fwd_btn,
    input  logic                       bwd_btn,
    input  logic                       rot_left_btn,
    input  logic                       rot_right_btn,
    output raycast_pkg::player_state_t state
);

    import raycast_pkg::*;

    // debounced levels
    logic clean_fwd;
    logic clean_bwd;
    logic clean_left;
    logic clean_right;

    // levels from the previous cycle
    logic past_fwd;
    logic past_bwd;
    logic past_left;
    logic past_right;

    move_cmd_t cmd_next;
    move_cmd_t cmd;

    debouncer i_deb_fwd (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .dirty_in  (fwd_btn),
        .clean_out (clean_fwd)
    );

    debouncer i_deb_bwd (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .dirty_in  (bwd_btn),
        .clean_out (clean_bwd)
    );

    debouncer i_deb_left (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .dirty_in  (rot_left_btn),
        .clean_out (clean_left)
    );

    debouncer i_deb_right (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .dirty_in  (rot_right_btn),
        .clean_out (clean_right)
    );

    // rising edges, fixed priority fwd > bwd > left > right
    always_comb begin
        cmd_next = '0;
        if (clean_fwd && !past_fwd) begin
            cmd_next.fwd = 1'b1;
        end else if (clean_bwd && !past_bwd) begin
            cmd_next.bwd = 1'b1;
        end else if (clean_left && !past_left) begin
            cmd_next.rot_left = 1'b1;
        end else if (clean_right && !past_right) begin
            cmd_next.rot_right = 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            past_fwd   <= 1'b0;
            past_bwd   <= 1'b0;
            past_left  <= 1'b0;
            past_right <= 1'b0;
            cmd        <= '0;
        end else begin
            past_fwd   <= clean_fwd;
            past_bwd   <= clean_bwd;
            past_left  <= clean_left;
            past_right <= clean_right;
            // losing edges are simply dropped
            cmd        <= cmd_next;
        end
    end

    movement_control i_movement_control (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .cmd    (cmd),
        .state  (state)
    );

endmodule

/* rtl/debouncer.sv */
`timescale 1ns/1ps
`include "raycast_macros.svh"

module debouncer (
    input  logic clk_in,
    input  logic rst_in,
    input  logic dirty_in,
    output logic clean_out
);

    localparam int CNT_W = $clog2(`DEB_COUNT + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            count     <= '0;
            clean_out <= 1'b0;
        end else if (dirty_in != clean_out) begin
            // input disagrees with the filtered level
            if (count == CNT_W'(`DEB_COUNT - 1)) begin
                clean_out <= dirty_in;
                count     <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end else begin
            // any bounce back restarts the wait
            count <= '0;
        end
    end

    // counter stays within the debounce window
    a_count_range: assert property (
        @(posedge clk_in) disable iff (rst_in)
        count <= CNT_W'(`DEB_COUNT)
    );

endmodule

/* rtl/fxp_rotate.sv */
`timescale 1ns/1ps
`include "raycast_macros.svh"

module fxp_rotate (
    input  raycast_pkg::vec2_t vec_in,
    input  logic               rot_left,
    output raycast_pkg::vec2_t vec_out
);

    import raycast_pkg::*;

    localparam fxp_t ROT_C = fxp_t'(`ROT_COS);
    localparam fxp_t ROT_S = fxp_t'(`ROT_SIN);

    fxp_t sin_v;

    // operands sign-extended to the product width
    logic signed [31:0] x_w;
    logic signed [31:0] y_w;
    logic signed [31:0] cos_w;
    logic signed [31:0] sin_w;

    // full-width products, already scaled back to 8.8
    logic signed [31:0] xc;
    logic signed [31:0] ys;
    logic signed [31:0] xs;
    logic signed [31:0] yc;

    logic signed [31:0] x_sum;
    logic signed [31:0] y_sum;

    always_comb begin
        // right turn is the same matrix with negated sine
        sin_v = rot_left ? ROT_S : -ROT_S;

        x_w   = vec_in.x;
        y_w   = vec_in.y;
        cos_w = ROT_C;
        sin_w = sin_v;

        xc = (x_w * cos_w) >>> 8;
        ys = (y_w * sin_w) >>> 8;
        xs = (x_w * sin_w) >>> 8;
        yc = (y_w * cos_w) >>> 8;

        x_sum = xc - ys;
        y_sum = xs + yc;

        // wrap to 16 bits
        vec_out.x = x_sum[15:0];
        vec_out.y = y_sum[15:0];
    end

endmodule

/* rtl/movement_control.sv */
`timescale 1ns/1ps
`include "raycast_macros.svh"

module movement_control (
    input  logic                       clk_in,
    input  logic                       rst_in,
    input  raycast_pkg::move_cmd_t     cmd,
    output raycast_pkg::player_state_t state
);

    import raycast_pkg::*;

    localparam player_state_t STATE_INIT = '{
        pos:   '{x: fxp_t'(`POS_INIT_X),   y: fxp_t'(`POS_INIT_Y)},
        dir:   '{x: fxp_t'(`DIR_INIT_X),   y: fxp_t'(`DIR_INIT_Y)},
        plane: '{x: fxp_t'(`PLANE_INIT_X), y: fxp_t'(`PLANE_INIT_Y)}
    };

    vec2_t step;
    vec2_t dir_rot;
    vec2_t plane_rot;

    // dir and plane turn together so the view stays consistent
    fxp_rotate i_rot_dir (
        .vec_in   (state.dir),
        .rot_left (cmd.rot_left),
        .vec_out  (dir_rot)
    );

    fxp_rotate i_rot_plane (
        .vec_in   (state.plane),
        .rot_left (cmd.rot_left),
        .vec_out  (plane_rot)
    );

    // quarter of dir per move
    always_comb begin
        step.x = state.dir.x >>> `STEP_SHIFT;
        step.y = state.dir.y >>> `STEP_SHIFT;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= STATE_INIT;
        end else if (cmd.fwd) begin
            state.pos.x <= state.pos.x + step.x;
            state.pos.y <= state.pos.y + step.y;
        end else if (cmd.bwd) begin
            state.pos.x <= state.pos.x - step.x;
            state.pos.y <= state.pos.y - step.y;
        end else if (cmd.rot_left || cmd.rot_right) begin
            // direction of turn is chosen inside the rotators
            state.dir   <= dir_rot;
            state.plane <= plane_rot;
        end
    end

    // the top encoder only ever issues one command at a time
    a_cmd_onehot: assert property (
        @(posedge clk_in) disable iff (rst_in)
        $onehot0(cmd)
    );

endmodule

/* rtl/raycast_macros.svh */
`ifndef RAYCAST_MACROS_SVH
`define RAYCAST_MACROS_SVH

// stable cycles before a debouncer accepts a new level
`define DEB_COUNT 16

// one step is a quarter of the direction vector
`define STEP_SHIFT 2

// 45 degree rotation, 8.8 fixed point (0.70703125)
`define ROT_COS 16'h00B5
`define ROT_SIN 16'h00B5

// player spawn point, 8.0 on both axes
`define POS_INIT_X 16'h0800
`define POS_INIT_Y 16'h0800

// facing -x at reset
`define DIR_INIT_X 16'hFF00
`define DIR_INIT_Y 16'h0000

// camera plane perpendicular to dir, about 0.66 wide
`define PLANE_INIT_X 16'h0000
`define PLANE_INIT_Y 16'h00A9

`endif

/* rtl/raycast_pkg.sv */
package raycast_pkg;

    // signed 8.8 fixed point
    typedef logic signed [15:0] fxp_t;

    // 2d vector, x in the upper half
    typedef struct packed {
        fxp_t x;
        fxp_t y;
    } vec2_t;

    // full player state as seen by the renderer
    typedef struct packed {
        vec2_t pos;
        vec2_t dir;
        vec2_t plane;
    } player_state_t;

    // one-cycle navigation command, at most one bit set
    typedef struct packed {
        logic fwd;
        logic bwd;
        logic rot_left;
        logic rot_right;
    } move_cmd_t;

endpackage

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f compile.f --top-module tb_btn_control -o sim_tb

# the simulator status is not trusted, the log decides
./obj_dir/sim_tb | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

/* tests/tb_btn_control.sv */
`timescale 1ns/1ps
`include "raycast_macros.svh"

module tb_btn_control;

    import raycast_pkg::*;

    localparam int HOLD_CYCLES = `DEB_COUNT + 10;
    // every press and glitch of the run, the long hold counted as three
    localparam int NUM_PRESSES = 54;
    localparam int TIMEOUT_CYCLES = NUM_PRESSES * 2 * HOLD_CYCLES + 500;
    localparam fxp_t COS_V = fxp_t'(`ROT_COS);
    localparam fxp_t SIN_V = fxp_t'(`ROT_SIN);

    logic          clk_in;
    logic          rst_in;
    logic          fwd_btn;
    logic          bwd_btn;
    logic          rot_left_btn;
    logic          rot_right_btn;
    player_state_t state;

    player_state_t model;
    logic [31:0]   lfsr_state;
    int            cycle_count;

    btn_control i_btn_control (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .fwd_btn       (fwd_btn),
        .bwd_btn       (bwd_btn),
        .rot_left_btn  (rot_left_btn),
        .rot_right_btn (rot_right_btn),
        .state         (state)
    );

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA3000000;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit
    function automatic int unsigned take_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = (v << 1) | {31'b0, lfsr_state[0]};
        end
        return v;
    endfunction

    // signed 8.8 product, scaled back by 8 bits
    function automatic fxp_t mul_shift(input fxp_t a, input fxp_t b);
        logic signed [31:0] wa;
        logic signed [31:0] wb;
        logic signed [31:0] p;
        wa = 32'(a);
        wb = 32'(b);
        p = (wa * wb) >>> 8;
        return p[15:0];
    endfunction

    function automatic vec2_t rotate_vec(input vec2_t v, input logic left);
        fxp_t  s;
        vec2_t r;
        s = left ? SIN_V : -SIN_V;
        r.x = mul_shift(v.x, COS_V) - mul_shift(v.y, s);
        r.y = mul_shift(v.x, s) + mul_shift(v.y, COS_V);
        return r;
    endfunction

    function automatic player_state_t init_state();
        player_state_t s;
        s.pos.x   = fxp_t'(`POS_INIT_X);
        s.pos.y   = fxp_t'(`POS_INIT_Y);
        s.dir.x   = fxp_t'(`DIR_INIT_X);
        s.dir.y   = fxp_t'(`DIR_INIT_Y);
        s.plane.x = fxp_t'(`PLANE_INIT_X);
        s.plane.y = fxp_t'(`PLANE_INIT_Y);
        return s;
    endfunction

    // buttons as {fwd, bwd, left, right}, highest priority wins
    function automatic move_cmd_t pick_cmd(input logic [3:0] b);
        move_cmd_t c;
        c = '0;
        if (b[3]) begin
            c.fwd = 1'b1;
        end else if (b[2]) begin
            c.bwd = 1'b1;
        end else if (b[1]) begin
            c.rot_left = 1'b1;
        end else if (b[0]) begin
            c.rot_right = 1'b1;
        end
        return c;
    endfunction

    function automatic player_state_t apply_cmd(input player_state_t s, input move_cmd_t c);
        player_state_t n;
        fxp_t          sx;
        fxp_t          sy;
        n  = s;
        sx = s.dir.x >>> `STEP_SHIFT;
        sy = s.dir.y >>> `STEP_SHIFT;
        if (c.fwd) begin
            n.pos.x = s.pos.x + sx;
            n.pos.y = s.pos.y + sy;
        end else if (c.bwd) begin
            n.pos.x = s.pos.x - sx;
            n.pos.y = s.pos.y - sy;
        end else if (c.rot_left || c.rot_right) begin
            n.dir   = rotate_vec(s.dir, c.rot_left);
            n.plane = rotate_vec(s.plane, c.rot_left);
        end
        return n;
    endfunction

    task automatic set_buttons(input logic [3:0] b);
        @(posedge clk_in);
        #1;
        fwd_btn       = b[3];
        bwd_btn       = b[2];
        rot_left_btn  = b[1];
        rot_right_btn = b[0];
    endtask

    task automatic check_equal(input string name, input logic [95:0] expected,
                               input logic [95:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "state check failed");
        end
    endtask

    // hold, release, then compare with the model
    task automatic press(input logic [3:0] b, input int hold, input string name);
        set_buttons(b);
        repeat (hold - 1) @(posedge clk_in);
        set_buttons(4'b0000);
        repeat (HOLD_CYCLES - 1) @(posedge clk_in);
        model = apply_cmd(model, pick_cmd(b));
        @(negedge clk_in);
        check_equal(name, model, state);
    endtask

    // pulse too short for the debouncer, model stays as it is
    task automatic glitch(input logic [3:0] b, input int len, input string name);
        set_buttons(b);
        repeat (len - 1) @(posedge clk_in);
        set_buttons(4'b0000);
        repeat (HOLD_CYCLES - 1) @(posedge clk_in);
        @(negedge clk_in);
        check_equal(name, model, state);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_in);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("FAIL: see errors above");
        $fatal(1, "timeout");
    end

    initial begin
        int sel;
        int len;
        rst_in        = 1'b1;
        fwd_btn       = 1'b0;
        bwd_btn       = 1'b0;
        rot_left_btn  = 1'b0;
        rot_right_btn = 1'b0;
        lfsr_state    = 32'hef3b0e85;
        repeat (3) @(posedge clk_in);
        #1;
        rst_in = 1'b0;

        model = init_state();
        @(negedge clk_in);
        check_equal("reset", model, state);

        press(4'b1000, HOLD_CYCLES, "fwd_step");
        press(4'b0100, HOLD_CYCLES, "bwd_return");
        check_equal("back_at_init", init_state(), state);
        press(4'b1000, 4 * HOLD_CYCLES, "fwd_long_hold");
        press(4'b0100, HOLD_CYCLES, "bwd_after_hold");

        press(4'b0010, HOLD_CYCLES, "rot_left");
        press(4'b0001, HOLD_CYCLES, "rot_right");
        for (int i = 0; i < 8; i++) begin
            sel = int'(take_bits(2));
            press(4'b0001 << sel, HOLD_CYCLES, $sformatf("single_%0d", i));
        end

        for (int i = 0; i < 6; i++) begin
            sel = int'(take_bits(2));
            len = 1 + int'(take_bits(4) % (`DEB_COUNT - 1));
            glitch(4'b0001 << sel, len, $sformatf("glitch_%0d", i));
        end

        press(4'b1010, HOLD_CYCLES, "fwd_and_left");
        press(4'b0101, HOLD_CYCLES, "bwd_and_right");

        // any button set, several at once included
        for (int i = 0; i < 30; i++) begin
            press(4'(take_bits(4)), HOLD_CYCLES, $sformatf("random_%0d", i));
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule
